// File: hw/cpuPkg.sv
package cpuPkg;

  ////////////////////
  // Base widths
  ////////////////////
  typedef logic [15:0] wordT;    // Data, instruction and address word
  typedef logic [3:0]  regAddrT; // Register index R0..R15

  ////////////////////
  // Opcodes
  ////////////////////
  // Top nibble of the instruction. Unlisted codes decode as no-op
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_NOR = 4'd3,
    OP_SLL = 4'd4,
    OP_SRL = 4'd5,
    OP_SRA = 4'd6,
    OP_LW  = 4'd8,
    OP_SW  = 4'd9,
    OP_LLB = 4'd10,
    OP_HLT = 4'd15
  } opcodeT;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_NOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASSB  // Second operand straight through, for LLB
  } aluOpT;

  ////////////////////
  // Pipeline structs
  ////////////////////
  typedef struct packed {
    logic  regWrite;  // Writes rd in WB
    logic  memRead;   // Load
    logic  memWrite;  // Store
    logic  memToReg;  // WB data from memory
    logic  useImm;    // ALU B from immediate
    logic  halt;
    aluOpT aluOp;
  } ctrlT;

  // Register write-back, also the retire record
  typedef struct packed {
    logic    valid;
    regAddrT addr;
    wordT    data;
  } wbT;

  typedef enum logic [1:0] {
    FWD_REG,  // Value read in ID
    FWD_MEM,  // From EX/MEM
    FWD_WB    // From MEM/WB
  } fwdSelT;

endpackage

// File: hw/decoder.sv
module decoder (
  input  cpuPkg::wordT    instr,
  output cpuPkg::ctrlT    ctrl,
  output cpuPkg::regAddrT srcA,
  output cpuPkg::regAddrT srcB,
  output cpuPkg::regAddrT dest
);
  import cpuPkg::*;

  opcodeT op;
  assign op = opcodeT'(instr[15:12]);

  always_comb begin
    ctrl = '0;          // No-op unless matched below
    srcA = instr[7:4];  // rs
    srcB = instr[3:0];  // rt
    dest = '0;          // Zero when nothing is written
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
        ctrl.regWrite = 1'b1;
        dest          = instr[11:8];
        case (op)
          OP_SUB:  ctrl.aluOp = ALU_SUB;
          OP_AND:  ctrl.aluOp = ALU_AND;
          OP_NOR:  ctrl.aluOp = ALU_NOR;
          default: ctrl.aluOp = ALU_ADD;
        endcase
      end
      OP_SLL, OP_SRL, OP_SRA: begin
        ctrl.regWrite = 1'b1;
        dest          = instr[11:8];
        srcB          = '0;  // [3:0] is shamt, no register read
        case (op)
          OP_SLL:  ctrl.aluOp = ALU_SLL;
          OP_SRL:  ctrl.aluOp = ALU_SRL;
          default: ctrl.aluOp = ALU_SRA;
        endcase
      end
      OP_LW: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.useImm   = 1'b1;  // Base plus offset
        ctrl.aluOp    = ALU_ADD;
        dest          = instr[11:8];
        srcB          = '0;
      end
      OP_SW: begin
        ctrl.memWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        ctrl.aluOp    = ALU_ADD;
        srcB          = instr[11:8];  // Store data register
      end
      OP_LLB: begin
        ctrl.regWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        ctrl.aluOp    = ALU_PASSB;
        dest          = instr[11:8];
        srcA          = '0;  // Fields are immediate bits
        srcB          = '0;
      end
      OP_HLT: begin
        ctrl.halt = 1'b1;
        srcA      = '0;
        srcB      = '0;
      end
      default: begin
        srcA = '0;  // Unused opcode reads nothing
        srcB = '0;
      end
    endcase
  end

endmodule

// File: hw/regFile.sv
module regFile (
  input  logic            clk,
  input  logic            rst,
  input  cpuPkg::regAddrT addrA,
  input  cpuPkg::regAddrT addrB,
  output cpuPkg::wordT    dataA,
  output cpuPkg::wordT    dataB,
  input  cpuPkg::wbT      wr
);
  import cpuPkg::*;

  wordT regs [16];

  // R0 hardwired to zero, same-cycle write bypassed to the reader
  function automatic wordT readPort(regAddrT addr);
    if (addr == '0) return '0;
    if (wr.valid && wr.addr == addr) return wr.data;  // Write before read
    return regs[addr];
  endfunction

  always_comb begin
    dataA = readPort(addrA);
    dataB = readPort(addrB);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) regs[i] <= '0;
    end else if (wr.valid && wr.addr != '0) begin
      regs[wr.addr] <= wr.data;  // R0 writes dropped
    end
  end

endmodule

// File: hw/alu.sv
module alu (
  input  cpuPkg::wordT  a,
  input  cpuPkg::wordT  b,
  input  cpuPkg::aluOpT op,
  input  logic [3:0]    shamt,
  output cpuPkg::wordT  result
);
  import cpuPkg::*;

  ////////////////////
  // Operation select
  ////////////////////
  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;  // Wraps at 16 bits
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_NOR: begin
        result = ~(a | b);
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SRL: begin
        result = a >> shamt;  // Zero fill
      end
      ALU_SRA: begin
        result = $signed(a) >>> shamt;  // Sign fill
      end
      ALU_PASSB: begin
        result = b;  // LLB immediate
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: hw/hazardUnit.sv
module hazardUnit (
  input  cpuPkg::regAddrT exSrcA,       // ID/EX sources
  input  cpuPkg::regAddrT exSrcB,
  input  cpuPkg::regAddrT memDest,      // EX/MEM writer
  input  logic            memRegWrite,
  input  cpuPkg::regAddrT wbDest,       // MEM/WB writer
  input  logic            wbRegWrite,
  input  cpuPkg::regAddrT exDest,       // Load in EX
  input  logic            exMemRead,
  input  cpuPkg::regAddrT idSrcA,       // IF/ID sources
  input  cpuPkg::regAddrT idSrcB,
  output cpuPkg::fwdSelT  fwdA,
  output cpuPkg::fwdSelT  fwdB,
  output logic            stall
);
  import cpuPkg::*;

  ////////////////////
  // Forwarding
  ////////////////////
  // Newest producer wins, R0 never forwarded
  function automatic fwdSelT pickSrc(regAddrT src);
    if (src != '0 && memRegWrite && src == memDest) return FWD_MEM;
    if (src != '0 && wbRegWrite && src == wbDest) return FWD_WB;
    return FWD_REG;
  endfunction

  always_comb begin
    fwdA = pickSrc(exSrcA);
    fwdB = pickSrc(exSrcB);
  end

  ////////////////////
  // Load-use
  ////////////////////
  logic loadDest;
  assign loadDest = exMemRead && exDest != '0;

  // Data not ready until MEM, so hold one cycle
  assign stall = loadDest && (exDest == idSrcA || exDest == idSrcB);

endmodule

// File: hw/dataMem.sv
module dataMem #(
  parameter int dmemWords = 256  // Power of two
) (
  input  logic         clk,
  input  cpuPkg::wordT addr,
  input  logic         wrEn,
  input  cpuPkg::wordT wrData,
  output cpuPkg::wordT rdData
);
  import cpuPkg::*;

  localparam int idxBits = $clog2(dmemWords);

  wordT               mem [dmemWords];
  logic [idxBits-1:0] idx;

  assign idx = addr[idxBits-1:0];  // Upper address bits ignored

  // Store lands on the edge at the end of MEM
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[idx] <= wrData;
    end
  end

  assign rdData = mem[idx];  // Combinational load

endmodule

// File: hw/cpuCore.sv
module cpuCore #(
  parameter int dmemWords = 256
) (
  input  logic         clk,
  input  logic         rst,
  output cpuPkg::wordT pc,      // Fetch address
  input  cpuPkg::wordT instr,   // Fetched word, same cycle
  output cpuPkg::wbT   retire,  // Register write-back report
  output logic         hlt
);
  import cpuPkg::*;

  ////////////////////
  // Pipeline regs
  ////////////////////
  typedef struct packed {
    logic valid;
    wordT instr;
  } ifIdT;

  typedef struct packed {
    ctrlT       ctrl;
    regAddrT    srcA;
    regAddrT    srcB;
    regAddrT    dest;
    wordT       dataA;
    wordT       dataB;
    wordT       imm;
    logic [3:0] shamt;
  } idExT;

  typedef struct packed {
    ctrlT    ctrl;
    regAddrT dest;
    wordT    aluRes;     // Result or memory address
    wordT    storeData;
  } exMemT;

  typedef struct packed {
    wbT   wb;
    logic halt;
  } memWbT;

  ifIdT  ifId;
  idExT  idEx;
  exMemT exMem;
  memWbT memWb;

  // ID
  ctrlT    decCtrl, idCtrl;
  regAddrT decSrcA, decSrcB, decDest;
  regAddrT idSrcA, idSrcB, idDest;
  wordT    rdA, rdB, idImm;
  logic    haltId, halting;
  // EX
  fwdSelT  fwdA, fwdB;
  wordT    opA, regB, aluB, aluRes;
  logic    stall;
  // MEM
  wordT    memRdData, wbData;

  ////////////////////
  // IF
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!(stall || haltId || halting)) begin
      pc <= pc + 16'd1;  // Frozen by stall or halt
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ifId.valid <= 1'b0;
    end else if (!stall) begin
      ifId.valid <= !(haltId || halting);  // Bubbles once HLT seen
      ifId.instr <= instr;
    end
  end

  ////////////////////
  // ID
  ////////////////////
  decoder i_decoder (
    .instr(ifId.instr),
    .ctrl (decCtrl),
    .srcA (decSrcA),
    .srcB (decSrcB),
    .dest (decDest)
  );

  // Empty slot decodes to nothing
  always_comb begin
    if (ifId.valid) begin
      idCtrl = decCtrl;
      idSrcA = decSrcA;
      idSrcB = decSrcB;
      idDest = decDest;
    end else begin
      idCtrl = '0;
      idSrcA = '0;
      idSrcB = '0;
      idDest = '0;
    end
  end

  regFile i_regFile (
    .clk  (clk),
    .rst  (rst),
    .addrA(idSrcA),
    .addrB(idSrcB),
    .dataA(rdA),
    .dataB(rdB),
    .wr   (memWb.wb)
  );

  // LLB takes 8 bits, LW/SW a 4-bit offset
  assign idImm = (ifId.instr[15:12] == OP_LLB) ? {{8{ifId.instr[7]}}, ifId.instr[7:0]}
                                               : {{12{ifId.instr[3]}}, ifId.instr[3:0]};

  assign haltId = idCtrl.halt;

  always_ff @(posedge clk) begin
    if (rst) halting <= 1'b0;
    else if (haltId) halting <= 1'b1;  // Sticky until reset
  end

  always_ff @(posedge clk) begin
    idEx.ctrl  <= idCtrl;
    idEx.srcA  <= idSrcA;
    idEx.srcB  <= idSrcB;
    idEx.dest  <= idDest;
    idEx.dataA <= rdA;
    idEx.dataB <= rdB;
    idEx.imm   <= idImm;
    idEx.shamt <= ifId.instr[3:0];
    if (rst || stall) begin
      idEx.ctrl <= '0;  // Bubble
      idEx.dest <= '0;
    end
  end

  ////////////////////
  // EX
  ////////////////////
  hazardUnit i_hazardUnit (
    .exSrcA     (idEx.srcA),
    .exSrcB     (idEx.srcB),
    .memDest    (exMem.dest),
    .memRegWrite(exMem.ctrl.regWrite),
    .wbDest     (memWb.wb.addr),
    .wbRegWrite (memWb.wb.valid),
    .exDest     (idEx.dest),
    .exMemRead  (idEx.ctrl.memRead),
    .idSrcA     (idSrcA),
    .idSrcB     (idSrcB),
    .fwdA       (fwdA),
    .fwdB       (fwdB),
    .stall      (stall)
  );

  function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
    case (sel)
      FWD_MEM: return memVal;
      FWD_WB:  return wbVal;
      default: return regVal;
    endcase
  endfunction

  assign opA  = fwdMux(fwdA, idEx.dataA, exMem.aluRes, memWb.wb.data);
  assign regB = fwdMux(fwdB, idEx.dataB, exMem.aluRes, memWb.wb.data);
  assign aluB = idEx.ctrl.useImm ? idEx.imm : regB;  // Store data keeps regB

  alu i_alu (
    .a     (opA),
    .b     (aluB),
    .op    (idEx.ctrl.aluOp),
    .shamt (idEx.shamt),
    .result(aluRes)
  );

  always_ff @(posedge clk) begin
    exMem.ctrl      <= idEx.ctrl;
    exMem.dest      <= idEx.dest;
    exMem.aluRes    <= aluRes;
    exMem.storeData <= regB;
    if (rst) begin
      exMem.ctrl <= '0;
      exMem.dest <= '0;
    end
  end

  ////////////////////
  // MEM
  ////////////////////
  dataMem #(.dmemWords(dmemWords)) i_dataMem (
    .clk   (clk),
    .addr  (exMem.aluRes),
    .wrEn  (exMem.ctrl.memWrite),
    .wrData(exMem.storeData),
    .rdData(memRdData)
  );

  assign wbData = exMem.ctrl.memToReg ? memRdData : exMem.aluRes;

  always_ff @(posedge clk) begin
    memWb.wb.addr <= exMem.dest;
    memWb.wb.data <= wbData;
    if (rst) begin
      memWb.wb.valid <= 1'b0;
      memWb.halt     <= 1'b0;
    end else begin
      memWb.wb.valid <= exMem.ctrl.regWrite && exMem.dest != '0;  // R0 never retires
      memWb.halt     <= exMem.ctrl.halt;
    end
  end

  ////////////////////
  // WB
  ////////////////////
  assign retire = memWb.wb;

  always_ff @(posedge clk) begin
    if (rst) hlt <= 1'b0;
    else if (memWb.halt) hlt <= 1'b1;  // Cycle after HLT leaves WB
  end

endmodule

// File: sim/clockGen.sv
module clockGen #(
  parameter int period = 100
) (
  output logic clk
);

  ////////////////////
  // Free-running clock
  ////////////////////
  initial clk = 1'b0;  // Low at time 0, first rising edge at half a period

  always #(period / 2) clk = ~clk;

endmodule

// File: sim/cpuTb.sv
module cpuTb;
  import cpuPkg::*;

  localparam int dmemWords  = 256;
  localparam int memIdxBits = $clog2(dmemWords);
  localparam int numTests   = 5;
  localparam int maxProg    = 128;

  logic clk;
  logic rst;
  wordT pc;
  wordT instr;
  wbT   retire;
  logic hlt;

  wordT imem [256];               // Fetch memory seen by the core
  wordT prog [numTests][maxProg];
  int   progLen [numTests];

  // ISA model state
  wordT mReg [16];
  wordT mMem [dmemWords];
  wbT   expQ [$];                 // Write-backs still owed by the core
  wordT haltPc;                   // Fetch address once HLT sits in ID

  int unsigned seedInit;
  int cycles      = 0;
  int cycleLimit  = 0;
  int checks      = 0;
  int errorTotal  = 0;
  int failedTests = 0;
  int testErrors;
  int testRetires;

  clockGen #(.period(100)) i_clockGen (.clk(clk));

  cpuCore #(.dmemWords(dmemWords)) i_cpuCore (
    .clk   (clk),
    .rst   (rst),
    .pc    (pc),
    .instr (instr),
    .retire(retire),
    .hlt   (hlt)
  );

  assign instr = imem[pc[7:0]];  // Combinational fetch

  ////////////////////
  // Program building
  ////////////////////
  function automatic wordT enc(opcodeT op, regAddrT rd, regAddrT rs, logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic regAddrT randReg();
    return regAddrT'($urandom_range(1, 15));  // Never R0
  endfunction

  function automatic regAddrT anyReg();
    return ($urandom_range(0, 2) == 0) ? 4'd0 : randReg();  // R0 about one time in three
  endfunction

  // Junk LLBs past the program, each one different per address
  function automatic wordT fillWord(int addr);
    return {OP_LLB, 4'(addr % 15 + 1), 8'(addr)};
  endfunction

  task automatic emit(int t, wordT w);
    prog[t][progLen[t]] = w;
    progLen[t]++;
  endtask

  task automatic primeRegs(int t, int count);
    logic [7:0] imm;
    for (int r = 1; r <= count; r++) begin
      imm = 8'($urandom);  // Half of them negative
      emit(t, enc(OP_LLB, regAddrT'(r), imm[7:4], imm[3:0]));
    end
  endtask

  task automatic independentOps(int t);
    logic [7:0] imm;
    primeRegs(t, 15);
    for (int i = 0; i < 30; i++) begin
      if ($urandom_range(0, 7) == 0) begin
        imm = 8'($urandom);
        emit(t, enc(OP_LLB, randReg(), imm[7:4], imm[3:0]));
      end else begin
        emit(t, enc(opcodeT'(4'($urandom_range(0, 6))), randReg(), randReg(), 4'($urandom)));
      end
    end
    emit(t, enc(OP_HLT, '0, '0, '0));
  endtask

  // Sources one, two or three back
  task automatic dependentChains(int t);
    regAddrT hist [3];  // Newest destination first
    regAddrT rd;
    primeRegs(t, 15);
    hist[0] = 4'd15;
    hist[1] = 4'd14;
    hist[2] = 4'd13;
    for (int i = 0; i < 30; i++) begin
      rd = randReg();
      if ($urandom_range(0, 4) == 0) begin
        emit(t, enc(opcodeT'(4'($urandom_range(4, 6))), rd, hist[0], 4'($urandom)));
      end else begin
        emit(t, enc(opcodeT'(4'($urandom_range(0, 3))), rd,
                    hist[$urandom_range(0, 1)], hist[$urandom_range(0, 2)]));
      end
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = rd;
    end
    emit(t, enc(OP_HLT, '0, '0, '0));
  endtask

  task automatic storeLoadPairs(int t);
    logic [7:0] imm;
    logic [3:0] off;
    regAddrT    base;
    regAddrT    loadDest;
    primeRegs(t, 15);
    for (int i = 0; i < 8; i++) begin
      imm      = 8'($urandom);
      off      = 4'($urandom);
      base     = randReg();
      loadDest = randReg();
      emit(t, enc(OP_LLB, base, imm[7:4], imm[3:0]));
      emit(t, enc(OP_SW, randReg(), base, off));
      emit(t, enc(OP_LW, loadDest, base, off));  // Same address as the store
      if ($urandom_range(0, 1) == 0) begin
        emit(t, enc(OP_ADD, randReg(), loadDest, randReg()));  // Load-use on rs
      end else begin
        emit(t, enc(OP_SUB, randReg(), randReg(), loadDest));  // Load-use on rt
      end
    end
    emit(t, enc(OP_HLT, '0, '0, '0));
  endtask

  task automatic zeroRegWrites(int t);
    logic [7:0] imm;
    primeRegs(t, 15);
    for (int i = 0; i < 24; i++) begin
      if ($urandom_range(0, 3) == 0) begin
        imm = 8'($urandom);
        emit(t, enc(OP_LLB, anyReg(), imm[7:4], imm[3:0]));
      end else begin
        emit(t, enc(opcodeT'(4'($urandom_range(0, 3))), anyReg(), anyReg(), anyReg()));
      end
    end
    emit(t, enc(OP_HLT, '0, '0, '0));
  endtask

  task automatic haltTail(int t);
    logic [7:0] imm;
    primeRegs(t, 6);
    for (int i = 0; i < 6; i++) begin
      emit(t, enc(opcodeT'(4'($urandom_range(0, 6))), randReg(), randReg(), 4'($urandom)));
    end
    emit(t, enc(OP_HLT, '0, '0, '0));
    for (int i = 0; i < 10; i++) begin
      imm = 8'($urandom);  // Dead code behind HLT
      emit(t, enc(OP_LLB, randReg(), imm[7:4], imm[3:0]));
    end
  endtask

  ////////////////////
  // ISA model
  ////////////////////
  task automatic modelRun(int t);
    wordT    w;
    wordT    a;
    wordT    b;
    wordT    r;
    wordT    addr;
    regAddrT rd;
    logic    writes;
    wbT      e;
    for (int i = 0; i < 16; i++) begin
      mReg[i] = '0;
    end
    expQ.delete();
    haltPc = '0;
    for (int i = 0; i < progLen[t]; i++) begin
      w      = prog[t][i];
      rd     = w[11:8];
      a      = mReg[w[7:4]];
      b      = mReg[w[3:0]];
      addr   = a + {{12{w[3]}}, w[3:0]};  // Base plus signed offset
      r      = '0;
      writes = 1'b1;
      if (opcodeT'(w[15:12]) == OP_HLT) begin
        haltPc = wordT'(i + 1);  // One past HLT, fetched while HLT decodes
        break;
      end
      case (opcodeT'(w[15:12]))
        OP_ADD: r = a + b;
        OP_SUB: r = a - b;
        OP_AND: r = a & b;
        OP_NOR: r = ~(a | b);
        OP_SLL: r = a << w[3:0];
        OP_SRL: r = a >> w[3:0];
        OP_SRA: begin
          r = a >> w[3:0];
          if (a[15]) r = r | ~(16'hFFFF >> w[3:0]);  // Refill vacated top bits
        end
        OP_LLB: r = {{8{w[7]}}, w[7:0]};
        OP_LW:  r = mMem[addr[memIdxBits-1:0]];
        OP_SW: begin
          mMem[addr[memIdxBits-1:0]] = mReg[rd];
          writes = 1'b0;
        end
        default: writes = 1'b0;
      endcase
      if (writes && rd != '0) begin
        mReg[rd] = r;
        e.valid  = 1'b1;
        e.addr   = rd;
        e.data   = r;
        expQ.push_back(e);
      end
    end
  endtask

  ////////////////////
  // Checking
  ////////////////////
  task automatic checkRetire();
    wbT exp;
    if (retire.valid) begin
      testRetires++;
      checks++;
      assert (retire.addr != '0) else begin
        $display("Retire at %0t reported a write to R0", $time);
        testErrors++;
      end
      assert (expQ.size() > 0) else begin
        $display("Unexpected retire at %0t: R%0d = %h after the last expected one",
                 $time, retire.addr, retire.data);
        testErrors++;
      end
      if (expQ.size() > 0) begin
        exp = expQ.pop_front();
        assert (retire.addr == exp.addr && retire.data == exp.data) else begin
          $display("MISMATCH at %0t: expected R%0d = %h, got R%0d = %h",
                   $time, exp.addr, exp.data, retire.addr, retire.data);
          testErrors++;
        end
      end
    end
  endtask

  task automatic runTest(int t, string name);
    testErrors  = 0;
    testRetires = 0;
    modelRun(t);
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < progLen[t]) ? prog[t][i] : fillWord(i);
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    do begin
      @(negedge clk);
      checkRetire();
    end while (!hlt);
    repeat (6) begin  // Core frozen once halted
      @(negedge clk);
      checks++;
      assert (!retire.valid) else begin
        $display("Retire valid at %0t after the core halted", $time);
        testErrors++;
      end
      assert (pc == haltPc) else begin
        $display("MISMATCH at %0t: pc after halt, expected %h, got %h", $time, haltPc, pc);
        testErrors++;
      end
      assert (hlt) else begin
        $display("hlt dropped at %0t without a reset", $time);
        testErrors++;
      end
    end
    assert (expQ.size() == 0) else begin
      $display("%0d expected retires never appeared before halt", expQ.size());
      testErrors++;
    end
    errorTotal += testErrors;
    if (testErrors != 0) failedTests++;
    $display("Test %0d %s: %s, %0d retires, %0d errors",
             t, name, (testErrors == 0) ? "PASS" : "FAIL", testRetires, testErrors);
  endtask

  // Watchdog on total cycles
  always @(negedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Timeout after %0d cycles, a program never reached its halt", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    rst      = 1'b1;
    seedInit = $urandom(8);
    for (int i = 0; i < 256; i++) begin
      imem[i] = fillWord(i);
    end
    for (int t = 0; t < numTests; t++) begin
      progLen[t] = 0;
    end
    independentOps(0);
    dependentChains(1);
    storeLoadPairs(2);
    zeroRegWrites(3);
    haltTail(4);
    for (int t = 0; t < numTests; t++) begin
      cycleLimit += 2 * progLen[t] + 20;
    end
    runTest(0, "independent ops");
    runTest(1, "dependent chains");
    runTest(2, "store/load pairs");
    runTest(3, "R0 writes");
    runTest(4, "halt with tail");
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             numTests, failedTests, checks, errorTotal);
    if (failedTests == 0 && errorTotal == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: files.f
hw/cpuPkg.sv
hw/decoder.sv
hw/regFile.sv
hw/alu.sv
hw/hazardUnit.sv
hw/dataMem.sv
hw/cpuCore.sv
sim/clockGen.sv
sim/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Some tests failed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
